// File: keypad_pkg.sv
package keypad_pkg;

  typedef logic [7:0] key_code_t; // {one-hot row, one-hot column}, zero when no key
  typedef logic [3:0] row_t;      // Row inputs, bit r is row r
  typedef logic [3:0] col_t;      // Column drive, one-hot, active high
  typedef logic [7:0] ascii_t;

  // Multi-tap states, TAPn means pending letter is group base plus n
  typedef enum logic [2:0] {
    IDLE = 3'd0, // No pending letter
    TAP0 = 3'd1,
    TAP1 = 3'd2,
    TAP2 = 3'd3,
    TAP3 = 3'd4, // Only reachable on 7 and 9
    DONE = 3'd5  // Letter handed to the word buffer
  } letter_state_t;

  // Layout by row: 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D
  localparam key_code_t key_2    = 8'b0001_0010; // R0 C1
  localparam key_code_t key_3    = 8'b0001_0100; // R0 C2
  localparam key_code_t key_4    = 8'b0010_0001; // R1 C0
  localparam key_code_t key_5    = 8'b0010_0010; // R1 C1
  localparam key_code_t key_6    = 8'b0010_0100; // R1 C2
  localparam key_code_t key_7    = 8'b0100_0001; // R2 C0
  localparam key_code_t key_8    = 8'b0100_0010; // R2 C1
  localparam key_code_t key_9    = 8'b0100_0100; // R2 C2
  localparam key_code_t key_c    = 8'b0100_1000; // R2 C3, end of game
  localparam key_code_t key_star = 8'b1000_0001; // R3 C0, submit letter
  localparam key_code_t key_0    = 8'b1000_0010; // R3 C1, clear letter
  localparam key_code_t key_hash = 8'b1000_0100; // R3 C2, submit word

  // First letter of the group printed on a key
  function automatic ascii_t key_base_letter(key_code_t code);
    ascii_t base;
    case (code)
      key_2:   base = "A";
      key_3:   base = "D";
      key_4:   base = "G";
      key_5:   base = "J";
      key_6:   base = "M";
      key_7:   base = "P"; // PQRS
      key_8:   base = "T";
      key_9:   base = "W"; // WXYZ
      default: base = 8'd0; // Control or unused key
    endcase
    return base;
  endfunction

  // Letters in the group, zero marks a key without letters
  function automatic logic [2:0] key_group_size(key_code_t code);
    logic [2:0] size;
    case (code)
      key_7, key_9:                      size = 3'd4;
      key_2, key_3, key_4, key_5, key_6: size = 3'd3;
      key_8:                             size = 3'd3;
      default:                           size = 3'd0;
    endcase
    return size;
  endfunction

endpackage

// File: keypad_scan.sv
`timescale 1ns/100ps

module keypad_scan #(
  parameter int SCAN_DIV       = 1000, // Cycles per column step, at least 3
  parameter int DEBOUNCE_SCANS = 3     // Full scans a code must hold
) (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::row_t      rows,
  output keypad_pkg::col_t      cols,
  output keypad_pkg::key_code_t key,
  output logic                  strobe
);
  localparam int div_w = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(SCAN_DIV - 1);
  localparam int cnt_w = $clog2(DEBOUNCE_SCANS + 1);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(DEBOUNCE_SCANS);

  logic [div_w-1:0]      div_cnt;    // Column step divider
  logic                  step;       // Last cycle on this column
  logic                  scan_end;   // Last cycle of a full scan
  keypad_pkg::row_t      rows_meta;  // Two-flop synchronizer on the rows
  keypad_pkg::row_t      rows_sync;
  keypad_pkg::key_code_t scan_acc;   // Key seen so far in this scan
  logic                  scan_multi; // More than one key seen in this scan
  keypad_pkg::key_code_t acc_next;
  logic                  multi_next;
  logic                  col_hit;
  logic                  col_multi;
  keypad_pkg::key_code_t scan_code;  // Result of the scan ending now
  keypad_pkg::key_code_t prev_code;  // Result of the previous full scan
  logic [cnt_w-1:0]      stable_cnt; // Consecutive scans with the same result
  logic [cnt_w-1:0]      stable_next;
  logic                  stable;
  logic                  armed;      // Cleared by a press, set by a stable release
  logic                  fire;

  assign step     = (div_cnt == div_last);
  assign scan_end = step && cols[3];

  // Fold the current column reading into the scan
  always_comb begin
    col_hit    = (rows_sync != '0);
    col_multi  = ((rows_sync & (rows_sync - 1'b1)) != '0); // Two rows in one column
    acc_next   = scan_acc;
    multi_next = scan_multi;
    if (col_hit) begin
      if ((scan_acc != '0) || col_multi) begin
        multi_next = 1'b1;
      end else begin
        acc_next = {rows_sync, cols};
      end
    end
    scan_code = multi_next ? '0 : acc_next; // Chords read as no key
  end

  // Stability count for the scan that ends this cycle
  always_comb begin
    if (scan_code != prev_code) begin
      stable_next = cnt_w'(1); // New code, first sighting
    end else if (stable_cnt != cnt_max) begin
      stable_next = stable_cnt + 1'b1;
    end else begin
      stable_next = stable_cnt; // Saturate
    end
  end

  assign stable = scan_end && (stable_next == cnt_max);
  assign fire   = stable && (scan_code != '0) && armed;

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      div_cnt    <= '0;
      cols       <= 4'b0001; // Column 0
      rows_meta  <= '0;
      rows_sync  <= '0;
      scan_acc   <= '0;
      scan_multi <= 1'b0;
      prev_code  <= '0;
      stable_cnt <= '0;
      armed      <= 1'b1;
      key        <= '0;
      strobe     <= 1'b0;
    end else begin
      rows_meta <= rows;
      rows_sync <= rows_meta;
      strobe    <= fire; // One cycle per accepted press

      if (step) begin
        div_cnt <= '0;
        cols    <= {cols[2:0], cols[3]}; // Rotate to next column
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end

      if (scan_end) begin
        scan_acc   <= '0; // Start a fresh scan
        scan_multi <= 1'b0;
        prev_code  <= scan_code;
        stable_cnt <= stable_next;
      end else if (step) begin
        scan_acc   <= acc_next;
        scan_multi <= multi_next;
      end

      // Stable press disarms, stable release re-arms
      if (stable) begin
        armed <= (scan_code == '0);
      end

      if (fire) begin
        key <= scan_code;
      end
    end
  end

endmodule

// File: keypad_fsm.sv
`timescale 1ns/100ps

module keypad_fsm (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic                  strobe,
  input  keypad_pkg::key_code_t key,
  output keypad_pkg::ascii_t    data,        // Pending letter, shown as preview
  output logic                  ready,       // Letter on data is submitted
  output logic                  word_submit,
  output logic                  game_end
);
  keypad_pkg::letter_state_t state;
  keypad_pkg::letter_state_t next_state;
  keypad_pkg::key_code_t     prev_key;       // Last letter key pressed
  keypad_pkg::key_code_t     next_prev_key;
  keypad_pkg::ascii_t        next_data;
  logic                      next_ready;
  logic                      next_word_submit;
  logic                      next_game_end;
  logic [2:0]                group_size;
  logic                      is_letter;
  logic                      is_tap;
  logic                      same_key;
  logic [1:0]                tap_idx;
  logic [1:0]                next_tap_idx;

  // Position in the letter group held by a TAP state
  function automatic logic [1:0] tap_of(keypad_pkg::letter_state_t s);
    logic [1:0] idx;
    case (s)
      keypad_pkg::TAP1: idx = 2'd1;
      keypad_pkg::TAP2: idx = 2'd2;
      keypad_pkg::TAP3: idx = 2'd3;
      default:          idx = 2'd0;
    endcase
    return idx;
  endfunction

  function automatic keypad_pkg::letter_state_t state_of(logic [1:0] idx);
    keypad_pkg::letter_state_t s;
    case (idx)
      2'd1:    s = keypad_pkg::TAP1;
      2'd2:    s = keypad_pkg::TAP2;
      2'd3:    s = keypad_pkg::TAP3;
      default: s = keypad_pkg::TAP0;
    endcase
    return s;
  endfunction

  assign group_size = keypad_pkg::key_group_size(key);
  assign is_letter  = (group_size != 3'd0);
  assign is_tap     = state inside {keypad_pkg::TAP0, keypad_pkg::TAP1,
                                    keypad_pkg::TAP2, keypad_pkg::TAP3};
  assign same_key   = is_tap && (key == prev_key); // Repeat press of the pending key
  assign tap_idx    = tap_of(state);

  // Step to next letter, wrap after the group's last one
  always_comb begin
    if (!same_key) begin
      next_tap_idx = 2'd0;
    end else if (({1'b0, tap_idx} + 3'd1) == group_size) begin
      next_tap_idx = 2'd0;
    end else begin
      next_tap_idx = tap_idx + 2'd1;
    end
  end

  always_comb begin
    next_state       = state;
    next_data        = data;
    next_prev_key    = prev_key;
    next_ready       = 1'b0;
    next_word_submit = 1'b0;
    next_game_end    = 1'b0;

    if (strobe) begin
      case (key)
        keypad_pkg::key_c: begin // Game over, drop everything
          next_state    = keypad_pkg::IDLE;
          next_data     = '0;
          next_prev_key = '0;
          next_game_end = 1'b1;
        end
        keypad_pkg::key_hash: begin
          next_state       = keypad_pkg::IDLE; // data kept for preview
          next_word_submit = 1'b1;
        end
        keypad_pkg::key_0: begin
          next_state = keypad_pkg::IDLE;
          next_data  = '0;
        end
        keypad_pkg::key_star: begin
          if (is_tap) begin // Nothing to submit in IDLE or DONE
            next_state = keypad_pkg::DONE;
            next_ready = 1'b1;
          end
        end
        default: begin
          if (is_letter) begin
            next_state    = state_of(next_tap_idx);
            // Letter follows the state being entered
            next_data     = keypad_pkg::key_base_letter(key) + {6'd0, next_tap_idx};
            next_prev_key = key;
          end
          // 1, A, B and D fall through untouched
        end
      endcase
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state       <= keypad_pkg::IDLE;
      prev_key    <= '0;
      data        <= '0;
      ready       <= 1'b0;
      word_submit <= 1'b0;
      game_end    <= 1'b0;
    end else begin
      state       <= next_state;
      prev_key    <= next_prev_key;
      data        <= next_data;
      ready       <= next_ready;
      word_submit <= next_word_submit;
      game_end    <= next_game_end;
    end
  end

endmodule

// File: word_buffer.sv
`timescale 1ns/100ps

module word_buffer #(
  parameter int WORD_LEN = 5 // Letters per word
) (
  input  logic                    clk,
  input  logic                    nRst,
  input  logic                    ready,       // Take data as the next letter
  input  logic                    word_submit,
  input  logic                    game_end,
  input  keypad_pkg::ascii_t      data,
  output logic [WORD_LEN*8-1:0]   word,        // First letter in the top byte
  output logic                    word_valid
);
  localparam int cnt_w = $clog2(WORD_LEN + 1);
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(WORD_LEN);

  keypad_pkg::ascii_t letters [WORD_LEN]; // Oldest at index 0 once full
  logic [cnt_w-1:0]   count;              // Letters held
  logic               full;
  logic               take;
  logic               flush;

  assign full  = (count == cnt_full);
  assign take  = ready && !full && !game_end;      // Extra letters dropped
  assign flush = word_submit && full && !game_end; // Partial words ignored

  // Shift in from the top, older letters move toward index 0
  always_ff @(posedge clk) begin
    if (take) begin
      for (int i = 0; i < WORD_LEN - 1; i++) begin
        letters[i] <= letters[i+1];
      end
      letters[WORD_LEN-1] <= data;
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      count      <= '0;
      word       <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= flush; // One cycle after word_submit

      if (game_end) begin
        count <= '0; // Abandon the partial word
      end else if (flush) begin
        count <= '0;
        // Pack with first letter most significant
        for (int i = 0; i < WORD_LEN; i++) begin
          word[(WORD_LEN-1-i)*8 +: 8] <= letters[i];
        end
      end else if (take) begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

// File: keypad_word_top.sv
`timescale 1ns/100ps

module keypad_word_top #(
  parameter int SCAN_DIV       = 1000,
  parameter int DEBOUNCE_SCANS = 3,
  parameter int WORD_LEN       = 5
) (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::row_t      rows,
  output keypad_pkg::col_t      cols,
  output keypad_pkg::ascii_t    data,       // Pending letter preview
  output logic                  ready,
  output logic                  word_valid,
  output logic                  game_end,
  output logic [WORD_LEN*8-1:0] word
);
  keypad_pkg::key_code_t key;    // Debounced key code
  logic                  strobe; // One pulse per press
  logic                  word_submit;

  // Matrix scan and debounce
  keypad_scan #(
    .SCAN_DIV       (SCAN_DIV),
    .DEBOUNCE_SCANS (DEBOUNCE_SCANS)
  ) u_scan (
    .clk    (clk),
    .nRst   (nRst),
    .rows   (rows),
    .cols   (cols),
    .key    (key),
    .strobe (strobe)
  );

  keypad_fsm u_fsm (
    .clk         (clk),
    .nRst        (nRst),
    .strobe      (strobe),
    .key         (key),
    .data        (data),
    .ready       (ready),
    .word_submit (word_submit),
    .game_end    (game_end)
  );

  // Collects submitted letters into a word
  word_buffer #(
    .WORD_LEN (WORD_LEN)
  ) u_buf (
    .clk         (clk),
    .nRst        (nRst),
    .ready       (ready),
    .word_submit (word_submit),
    .game_end    (game_end),
    .data        (data),
    .word        (word),
    .word_valid  (word_valid)
  );

endmodule

// File: keypad_word_properties.sv
`timescale 1ns/100ps

module keypad_word_properties (
  input logic             clk,
  input logic             nRst,
  input keypad_pkg::col_t cols,
  input logic             strobe,
  input logic             ready,
  input logic             game_end,
  input logic             word_valid
);
  // Exactly one column driven at a time
  a_cols_onehot: assert property (@(posedge clk) disable iff (!nRst) $onehot(cols))
    else $error("cols not one-hot: %b", cols);

  a_strobe_single: assert property (@(posedge clk) disable iff (!nRst) strobe |=> !strobe)
    else $error("strobe high for two cycles"); // One strobe per press

  a_ready_vs_end: assert property (@(posedge clk) disable iff (!nRst) !(ready && game_end))
    else $error("ready and game_end high together");

  a_valid_single: assert property (@(posedge clk) disable iff (!nRst)
                                   word_valid |=> !word_valid)
    else $error("word_valid high for two cycles");

endmodule

// Attach to every keypad_word_top instance
bind keypad_word_top keypad_word_properties u_props (
  .clk        (clk),
  .nRst       (nRst),
  .cols       (cols),
  .strobe     (strobe),
  .ready      (ready),
  .game_end   (game_end),
  .word_valid (word_valid)
);

// File: tb_keypad_word.sv
`timescale 1ns/100ps

module tb_keypad_word;
  localparam int WORD_LEN      = 5;
  localparam int HOLD_CYCLES   = 80; // Longest press to pulse path plus margin
  localparam int SETTLE_CYCLES = 64; // Two clean scans re-arm the scanner
  localparam keypad_pkg::key_code_t key_1 = 8'b0001_0001; // Keys with no meaning
  localparam keypad_pkg::key_code_t key_a = 8'b0001_1000;
  localparam keypad_pkg::key_code_t key_b = 8'b0010_1000;
  localparam keypad_pkg::key_code_t key_d = 8'b1000_1000;
  localparam keypad_pkg::key_code_t letter_keys [8] = '{keypad_pkg::key_2, keypad_pkg::key_3,
    keypad_pkg::key_4, keypad_pkg::key_5, keypad_pkg::key_6, keypad_pkg::key_7,
    keypad_pkg::key_8, keypad_pkg::key_9};

  logic                  clk;
  logic                  nRst;
  keypad_pkg::row_t      rows;
  keypad_pkg::col_t      cols;
  keypad_pkg::ascii_t    data;
  logic                  ready;
  logic                  word_valid;
  logic                  game_end;
  logic [WORD_LEN*8-1:0] word;
  keypad_pkg::key_code_t held;   // Key pressed on the model or zero
  int errors;
  int checks;
  int tests_run;
  int tests_failed;

  // Keypad model drives the held key's row while its column is driven
  assign rows = ((held[3:0] & cols) != '0) ? held[7:4] : '0;

  always #20 clk = ~clk; // 40 ns period

  keypad_word_top #(.SCAN_DIV(4), .DEBOUNCE_SCANS(2), .WORD_LEN(WORD_LEN)) dut0 (
    .clk(clk), .nRst(nRst), .rows(rows), .cols(cols), .data(data),
    .ready(ready), .word_valid(word_valid), .game_end(game_end), .word(word)
  );

  task automatic check_ascii(input string what, input keypad_pkg::ascii_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t ns: %s got '%c' (%h) expected '%c' (%h)", $time, what,
               got, got, exp, exp);
    end
  endtask

  task automatic check_word(input string what, input logic [WORD_LEN*8-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t ns: %s got \"%s\" expected \"%s\"", $time, what, got, exp);
    end
  endtask

  task automatic check_pulse(input string what, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cols(input string what, input keypad_pkg::col_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Press and hold until a pulse or the hold time, then release and settle
  task automatic press_key(input keypad_pkg::key_code_t code, input logic exp_ready,
                           input logic exp_end, input logic exp_valid);
    logic got_ready = 1'b0;
    logic got_end   = 1'b0;
    logic got_valid = 1'b0;
    int   n         = 0;
    @(posedge clk);
    held <= code;
    while (!(got_ready || got_end || got_valid) && n < HOLD_CYCLES) begin
      @(negedge clk);
      got_ready = ready;
      got_end   = game_end;
      got_valid = word_valid;
      n++;
    end
    @(posedge clk);
    held <= '0;
    for (n = 0; n < SETTLE_CYCLES; n++) begin
      @(negedge clk);
      got_ready |= ready; // Late or stray pulses still count
      got_end   |= game_end;
      got_valid |= word_valid;
    end
    check_pulse("ready pulse", got_ready, exp_ready);
    check_pulse("game_end pulse", got_end, exp_end);
    check_pulse("word_valid pulse", got_valid, exp_valid);
  endtask

  // Tap the letter's key until it shows and submit it with '*'
  task automatic type_letter(input keypad_pkg::ascii_t letter);
    keypad_pkg::key_code_t code = '0;
    int base;
    int taps = 0;
    foreach (letter_keys[i]) begin
      base = int'(keypad_pkg::key_base_letter(letter_keys[i]));
      if (int'(letter) >= base &&
          int'(letter) < base + int'(keypad_pkg::key_group_size(letter_keys[i]))) begin
        code = letter_keys[i];
        taps = int'(letter) - base + 1;
      end
    end
    for (int t = 0; t < taps; t++) begin
      press_key(code, 1'b0, 1'b0, 1'b0);
    end
    check_ascii("pending letter", data, letter);
    press_key(keypad_pkg::key_star, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic type_string(input string s);
    for (int i = 0; i < s.len(); i++) begin
      type_letter(s[i]);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset();
    int e0 = errors;
    repeat (16) @(posedge clk);
    nRst <= 1'b1;
    @(negedge clk);
    check_cols("cols after reset", cols, 4'b0001);
    check_ascii("data after reset", data, 8'd0);
    check_pulse("ready after reset", ready, 1'b0);
    check_pulse("word_valid after reset", word_valid, 1'b0);
    check_pulse("game_end after reset", game_end, 1'b0);
    check_word("word after reset", word, '0);
    finish_test("reset", e0);
  endtask

  task automatic test_multitap();
    int    e0   = errors;
    string exp7 = "PQRSP"; // Fifth tap wraps to the first letter
    string exp9 = "WXYZW";
    for (int i = 0; i < 5; i++) begin
      press_key(keypad_pkg::key_7, 1'b0, 1'b0, 1'b0);
      check_ascii("tap on 7", data, exp7[i]);
    end
    for (int i = 0; i < 5; i++) begin
      press_key(keypad_pkg::key_9, 1'b0, 1'b0, 1'b0);
      check_ascii("tap on 9", data, exp9[i]);
    end
    press_key(keypad_pkg::key_star, 1'b1, 1'b0, 1'b0);
    check_ascii("submitted letter", data, "W");
    finish_test("multitap", e0);
  endtask

  task automatic test_clear_ignored();
    int                    e0 = errors;
    keypad_pkg::key_code_t dead [4] = '{key_1, key_a, key_b, key_d};
    press_key(keypad_pkg::key_4, 1'b0, 1'b0, 1'b0);
    press_key(keypad_pkg::key_4, 1'b0, 1'b0, 1'b0);
    check_ascii("second tap on 4", data, "H");
    press_key(keypad_pkg::key_0, 1'b0, 1'b0, 1'b0);
    check_ascii("data after clear", data, 8'd0);
    press_key(keypad_pkg::key_6, 1'b0, 1'b0, 1'b0);
    foreach (dead[i]) begin
      press_key(dead[i], 1'b0, 1'b0, 1'b0);
      check_ascii("data after ignored key", data, "M");
    end
    press_key(keypad_pkg::key_0, 1'b0, 1'b0, 1'b0);
    press_key(keypad_pkg::key_star, 1'b0, 1'b0, 1'b0); // Nothing pending
    check_ascii("data after idle submit", data, 8'd0);
    finish_test("clear", e0);
  endtask

  task automatic test_word();
    int e0 = errors;
    press_key(keypad_pkg::key_c, 1'b0, 1'b1, 1'b0); // New game starts with an empty buffer
    type_string("HELLO");
    press_key(keypad_pkg::key_hash, 1'b0, 1'b0, 1'b1);
    check_word("full word", word, "HELLO");
    type_string("ABCD");
    press_key(keypad_pkg::key_hash, 1'b0, 1'b0, 1'b0); // Short word held back
    check_word("word after short submit", word, "HELLO");
    type_string("EF"); // F overflows and is dropped
    press_key(keypad_pkg::key_hash, 1'b0, 1'b0, 1'b1);
    check_word("word after overflow", word, "ABCDE");
    finish_test("word", e0);
  endtask

  task automatic test_random();
    int                    e0 = errors;
    logic [WORD_LEN*8-1:0] exp;
    keypad_pkg::ascii_t    letter;
    for (int w = 0; w < 3; w++) begin
      exp = '0;
      for (int i = 0; i < WORD_LEN; i++) begin
        letter = 8'(32'd65 + ($urandom % 26)); // 'A' to 'Z'
        exp    = {exp[WORD_LEN*8-9:0], letter};
        type_letter(letter);
      end
      press_key(keypad_pkg::key_hash, 1'b0, 1'b0, 1'b1);
      check_word("random word", word, exp);
    end
    finish_test("random", e0);
  endtask

  task automatic test_game_end();
    int e0 = errors;
    type_string("GA");
    press_key(keypad_pkg::key_c, 1'b0, 1'b1, 1'b0);
    check_ascii("data after game end", data, 8'd0);
    type_string("WORDS"); // Leftover GA would shift into the front
    press_key(keypad_pkg::key_hash, 1'b0, 1'b0, 1'b1);
    check_word("word after game end", word, "WORDS");
    finish_test("game_end", e0);
  endtask

  initial begin
    clk          = 1'b0;
    nRst         = 1'b0;
    held         = '0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'hcfa));
    test_reset();
    test_multitap();
    test_clear_ignored();
    test_word();
    test_random();
    test_game_end();
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
keypad_pkg.sv
keypad_scan.sv
keypad_fsm.sv
word_buffer.sv
keypad_word_top.sv
keypad_word_properties.sv
tb_keypad_word.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_keypad_word
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
